//--- Bender.yml
package:
  name: scan_doubler

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/scan_doubler_pkg.sv
      - verilog/sd_line_timing.sv
      - verilog/sd_line_buffer.sv
      - verilog/sd_readout.sv
      - verilog/sd_scanline.sv
      - verilog/scan_doubler.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tb/scan_doubler_asserts.sv
      - tb/tb_scan_doubler.sv

//--- scan_doubler.f
+incdir+verilog
verilog/scan_doubler_pkg.sv
verilog/sd_line_timing.sv
verilog/sd_line_buffer.sv
verilog/sd_readout.sv
verilog/sd_scanline.sv
verilog/scan_doubler.sv
tb/scan_doubler_asserts.sv
tb/tb_scan_doubler.sv

//--- tb/scan_doubler_asserts.sv
// concurrent checks on the readout stage of the scan doubler
// bound into sd_readout, sees the line start pulse, the read address,
// the regenerated hsync and the read stream
// failures are counted so the testbench can end the run on them

`timescale 1ns/1ps
`default_nettype none

`include "scan_doubler_defines.svh"

module scan_doubler_asserts
  import scan_doubler_pkg::*;
(
  input logic                     clk,
  input logic                     arst_n,
  input logic                     line_start,
  input logic [`SD_HCNT_BITS-1:0] rd_addr,
  input logic                     hs_gen,
  input vid_t                     vid_rd
);

  // number of failed assertions so far
  int fail_count = 0;

  // ========================================
  // properties
  // ========================================

  // line start is a single clk pulse
  assert property (@(posedge clk) disable iff (!arst_n) line_start |=> !line_start)
    else begin
      $error("line_start longer than one cycle");
      fail_count++;
    end

  // whole stream held low in reset
  assert property (@(posedge clk) !arst_n |-> vid_rd == '0)
    else begin
      $error("read stream not low during reset");
      fail_count++;
    end

  // hsync only drops where the counter has wrapped to address zero
  assert property (@(posedge clk) disable iff (!arst_n) $fell(hs_gen) |-> rd_addr == '0)
    else begin
      $error("output hsync fell without counter wrap");
      fail_count++;
    end

endmodule

bind sd_readout scan_doubler_asserts u_asserts (
  .clk        (clk),
  .arst_n     (arst_n),
  .line_start (meas.line_start),
  .rd_addr    (rd_addr),
  .hs_gen     (hs_gen),
  .vid_rd     (vid_rd)
);

`default_nettype wire

//--- tb/tb_scan_doubler.sv
// testbench for the scan doubler
// drives random 15 kHz lines with an LFSR and checks reset, line doubling,
// pixel replay, scanline dimming, the 15 kHz flag and vsync delay
// against a stream model kept here

`timescale 1ns/1ps
`default_nettype none

`include "scan_doubler_defines.svh"

module tb_scan_doubler
  import scan_doubler_pkg::*;
();

  localparam int RESET_CYCLES = 16;
  localparam int N_GROUPS     = 6;
  localparam int GROUP_LINES  = 3;
  localparam int FALL_TIMEOUT = 4096;
  localparam int STREAM_SIZE  = 65536;
  localparam int MAX_LINES    = 64;

  logic     clk;
  logic     arst_n;
  logic     pix_en;
  vid_t     vid_in;
  sl_mode_t sl_mode;
  vid_t     vid_out;
  logic     is15k;

  // every driven input pixel in order, plus per line bookkeeping
  rgb_t stream [0:STREAM_SIZE-1];
  int   n_samples = 0;
  int   line_e0  [0:MAX_LINES-1];
  int   line_s   [0:MAX_LINES-1];
  int   line_len [0:MAX_LINES-1];
  int   line_hsw [0:MAX_LINES-1];
  int   n_lines = 0;

  // recent vsync and mode per clk, indexed by cycle modulo 8
  logic     vs_ring   [0:7];
  sl_mode_t mode_ring [0:7];

  int          cyc = 0;
  logic [31:0] lfsr;
  bit          drive_done = 0;
  int          checked_lines = 0;

  // output side model
  logic     prev_hs;
  logic     prev_vs;
  logic     phase_m;
  logic     out_fell;
  sl_mode_t mode_now;

  scan_doubler dut (
    .clk     (clk),
    .arst_n  (arst_n),
    .pix_en  (pix_en),
    .vid_in  (vid_in),
    .sl_mode (sl_mode),
    .vid_out (vid_out),
    .is15k   (is15k)
  );

  always #10 clk = ~clk;

  // posedge count, read on negedges only
  always @(posedge clk) cyc <= cyc + 1;

  // ========================================
  // helpers
  // ========================================

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic take_bits(input int n, output int val);
    val = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      val  = (val << 1) | int'(lfsr[0]);
    end
  endtask

  function automatic logic [`SD_COLOR_BITS-1:0] scanline_level(
    input sl_mode_t                  mode,
    input logic [`SD_COLOR_BITS-1:0] c
  );
    logic [`SD_COLOR_BITS-1:0] q;
    q = c;
    if (mode == SL_HALF) begin
      q = c >> 1;
    end else if (mode == SL_QUARTER) begin
      q = c - (c >> 2);
    end
    return q;
  endfunction

  function automatic rgb_t expected_rgb(input rgb_t raw, input sl_mode_t mode,
                                        input logic dimmed);
    rgb_t e;
    e = raw;
    if (dimmed) begin
      e.r = scanline_level(mode, raw.r);
      e.g = scanline_level(mode, raw.g);
      e.b = scanline_level(mode, raw.b);
    end
    return e;
  endfunction

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    if (exp !== act) begin
      $display("Fail %s expected %0h actual %0h", name, exp, act);
      $display("Test failures found");
      $fatal(1, "value mismatch");
    end
  endtask

  // stop at the first failed bound assertion
  always @(negedge clk) begin
    if (dut.u_readout.u_asserts.fail_count != 0) begin
      stop_with_failure("a bound concurrent assertion failed");
    end
  end

  // ========================================
  // stimulus
  // ========================================

  task automatic drive_cycle(input logic en, input vid_t v, input sl_mode_t mode);
    @(negedge clk);
    pix_en  = en;
    vid_in  = v;
    sl_mode = mode;
    vs_ring[cyc % 8]   = v.vs;
    mode_ring[cyc % 8] = mode;
  endtask

  // one input line, hsync low for the first hs_w pixels
  task automatic drive_line(input int len, input int hs_w, input logic vs,
                            input sl_mode_t mode);
    vid_t v;
    int   bits;
    for (int j = 0; j < len; j++) begin
      take_bits(3 * `SD_COLOR_BITS, bits);
      v.hs  = (j >= hs_w);
      v.vs  = vs;
      v.rgb = rgb_t'(bits[3*`SD_COLOR_BITS-1:0]);
      drive_cycle(1'b1, v, mode);
      if (j == 0) begin
        // pixel 0 is sampled on the next posedge
        line_e0[n_lines]  = cyc + 1;
        line_s[n_lines]   = n_samples;
        line_len[n_lines] = len;
        line_hsw[n_lines] = hs_w;
        n_lines++;
      end
      stream[n_samples] = v.rgb;
      n_samples++;
      drive_cycle(1'b0, v, mode);
    end
  endtask

  // even groups are long 15 kHz lines, odd groups short ones
  task automatic run_driver();
    int       len;
    int       hs_w;
    int       bits;
    logic     vs;
    sl_mode_t mode;
    vs = 1'b0;
    for (int g = 0; g < N_GROUPS; g++) begin
      take_bits(10, bits);
      if (g % 2 == 0) begin
        len = 802 + bits % 222;
      end else begin
        len = 128 + bits % 673;
      end
      take_bits(5, bits);
      hs_w = 8 + bits;
      mode = sl_mode_t'(g % 3);
      // new frame, output phase must restart
      if (g == 2 || g == 4) begin
        vs = ~vs;
      end
      for (int l = 0; l < GROUP_LINES; l++) begin
        drive_line(len, hs_w, vs, mode);
      end
    end
    drive_done = 1;
  endtask

  // ========================================
  // output checking
  // ========================================

  // one clk of output, tracks the scanline phase and checks vsync delay
  task automatic sample_out();
    @(negedge clk);
    out_fell = prev_hs & ~vid_out.hs;
    if (prev_vs != vid_out.vs) begin
      phase_m = 1'b0;
    end else if (out_fell) begin
      phase_m = ~phase_m;
    end
    mode_now = mode_ring[(cyc - 1) % 8];
    check_value("vsync delay", vs_ring[(cyc - 3) % 8], vid_out.vs);
    prev_hs = vid_out.hs;
    prev_vs = vid_out.vs;
  endtask

  task automatic wait_out_fall(output bit found);
    int n;
    found = 0;
    n     = 0;
    while (!found && !drive_done) begin
      if (n >= FALL_TIMEOUT) begin
        stop_with_failure("no output hsync falling edge within the timeout");
      end else begin
        sample_out();
        found = out_fell;
        n++;
      end
    end
  endtask

  // line whose start edge lies 3 or 4 clk before the output fall
  function automatic int find_line(input int f);
    int r;
    r = -1;
    for (int j = n_lines - 1; j >= 0 && j >= n_lines - 4; j--) begin
      if (f - line_e0[j] == 3 || f - line_e0[j] == 4) begin
        r = j;
      end
    end
    return r;
  endfunction

  task automatic check_pixel(input string name, input int idx);
    check_value(name, expected_rgb(stream[idx], mode_now, phase_m), vid_out.rgb);
  endtask

  // stored address k holds input sample k+1 of line n
  task automatic check_line_pair(input int n);
    int len;
    int base;
    int hs_w;
    len  = line_len[n];
    base = line_s[n] + 1;
    hs_w = line_hsw[n];
    check_value("15 kHz detect", (len - 1) > `SD_15K_LIMIT, is15k);
    check_pixel("pixel replay first copy", base);
    for (int k = 1; k < len; k++) begin
      sample_out();
      check_value("hsync inside line", 0, out_fell);
      // output sync pulse keeps the input pulse width
      check_value("output hsync level", k >= hs_w, vid_out.hs);
      check_pixel("pixel replay first copy", base + k);
    end
    sample_out();
    check_value("line doubling interval", 1, out_fell);
    check_pixel("pixel replay second copy", base);
    // the last two reads cross into the next buffer swap
    for (int k = 1; k < len - 2; k++) begin
      sample_out();
      check_pixel("pixel replay second copy", base + k);
    end
    checked_lines++;
  endtask

  task automatic run_checker();
    bit found;
    int i;
    prev_hs = vid_out.hs;
    prev_vs = vid_out.vs;
    phase_m = 1'b0;
    while (!drive_done) begin
      wait_out_fall(found);
      if (found) begin
        i = find_line(cyc);
        // only lines with a measured start and an equal successor
        if (i >= 2 && line_len[i-1] == line_len[i]) begin
          check_line_pair(i - 1);
        end
      end
    end
  endtask

  // ========================================
  // main sequence
  // ========================================

  initial begin
    clk     = 1'b0;
    arst_n  = 1'b0;
    pix_en  = 1'b0;
    vid_in  = '0;
    sl_mode = SL_OFF;
    lfsr    = 32'hf9a0_e7a6;
    for (int i = 0; i < 8; i++) begin
      vs_ring[i]   = 1'b0;
      mode_ring[i] = SL_OFF;
    end
    for (int n = 0; n < RESET_CYCLES; n++) begin
      @(negedge clk);
      check_value("reset vid_out", 0, vid_out);
      check_value("reset is15k", 0, is15k);
    end
    arst_n = 1'b1;
    @(negedge clk);
    check_value("after reset vid_out", 0, vid_out);
    check_value("after reset is15k", 0, is15k);
    fork
      run_driver();
      run_checker();
    join
    if (checked_lines < N_GROUPS) begin
      stop_with_failure("too few output lines were checked");
    end else if (dut.u_readout.u_asserts.fail_count != 0) begin
      stop_with_failure("a bound concurrent assertion failed");
    end else begin
      $display("All tests passed!");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- verilog/scan_doubler.sv
// top level of the VGA scan doubler for 15 kHz sources
// clk runs at twice the source pixel rate, pix_en marks source pixels
// vid_out carries the doubled line rate with optional scanlines
// is15k reports a slow input line rate

`timescale 1ns/1ps
`default_nettype none

`include "scan_doubler_defines.svh"

module scan_doubler
  import scan_doubler_pkg::*;
(
  input  logic     clk,
  input  logic     arst_n,
  input  logic     pix_en,
  input  vid_t     vid_in,
  input  sl_mode_t sl_mode,
  output vid_t     vid_out,
  output logic     is15k
);

  // line measurement towards buffer and readout
  line_meas_t meas;

  // buffer addresses and read data
  logic [`SD_HCNT_BITS-1:0] wr_addr;
  logic [`SD_HCNT_BITS-1:0] rd_addr;
  rgb_t                     rd_rgb;

  // read stream before the output register
  vid_t vid_rd;

  sd_line_timing u_line_timing (
    .clk     (clk),
    .arst_n  (arst_n),
    .pix_en  (pix_en),
    .vid_in  (vid_in),
    .meas    (meas),
    .wr_addr (wr_addr),
    .is15k   (is15k)
  );

  sd_line_buffer u_line_buffer (
    .clk     (clk),
    .pix_en  (pix_en),
    .wr_sel  (meas.line_sel),
    .wr_addr (wr_addr),
    .wr_rgb  (vid_in.rgb),
    .rd_addr (rd_addr),
    .rd_rgb  (rd_rgb)
  );

  // vsync bypasses the buffer and is delayed inside the readout
  sd_readout u_readout (
    .clk     (clk),
    .arst_n  (arst_n),
    .meas    (meas),
    .vs_in   (vid_in.vs),
    .rd_rgb  (rd_rgb),
    .rd_addr (rd_addr),
    .vid_rd  (vid_rd)
  );

  sd_scanline u_scanline (
    .clk     (clk),
    .arst_n  (arst_n),
    .sl_mode (sl_mode),
    .vid_rd  (vid_rd),
    .vid_out (vid_out)
  );

endmodule

`default_nettype wire

//--- verilog/scan_doubler_defines.svh
// sizing constants for the scan doubler
// pulled in by the package and by every module that needs a raw width
// change these here only, all ports and memories follow

`ifndef SCAN_DOUBLER_DEFINES_SVH
`define SCAN_DOUBLER_DEFINES_SVH

// ========================================
// horizontal counters
// ========================================

// 10 bit pixel counters allow up to 1024 pixels per input line
`define SD_HCNT_BITS 10

// ========================================
// colour and detection
// ========================================

// bits per colour channel, wide enough to dim in two steps
`define SD_COLOR_BITS 4

// lines longer than this many input pixels are taken as 15 kHz video
`define SD_15K_LIMIT 800

`endif

//--- verilog/scan_doubler_pkg.sv
// shared types for the scan doubler
// video travels between the stages as packed structs
// modules import this with a wildcard in their header

`default_nettype none

`include "scan_doubler_defines.svh"

package scan_doubler_pkg;

  // one pixel worth of colour
  typedef struct packed {
    logic [`SD_COLOR_BITS-1:0] r;
    logic [`SD_COLOR_BITS-1:0] g;
    logic [`SD_COLOR_BITS-1:0] b;
  } rgb_t;

  // sync flags plus colour, used at both ends of the pipeline
  typedef struct packed {
    logic hs;
    logic vs;
    rgb_t rgb;
  } vid_t;

  // result of the input line analysis
  // hs_max is the last line length minus one
  // hs_rise is the pixel index where hsync went high
  // line_sel names the buffer half now being written
  // line_start pulses for one clk when a new input line begins
  typedef struct packed {
    logic [`SD_HCNT_BITS-1:0] hs_max;
    logic [`SD_HCNT_BITS-1:0] hs_rise;
    logic                     line_sel;
    logic                     line_start;
  } line_meas_t;

  // scanline effect on every second output line
  typedef enum logic [1:0] {
    SL_OFF     = 2'd0,
    SL_HALF    = 2'd1,
    SL_QUARTER = 2'd2
  } sl_mode_t;

endpackage

`default_nettype wire

//--- verilog/sd_line_buffer.sv
// ping-pong line store for the scan doubler
// one half takes the incoming line at the input pixel rate while
// the other half is read back at the output rate
// read data appears one clk after the address

`timescale 1ns/1ps
`default_nettype none

`include "scan_doubler_defines.svh"

module sd_line_buffer
  import scan_doubler_pkg::*;
(
  input  logic                     clk,
  input  logic                     pix_en,
  input  logic                     wr_sel,
  input  logic [`SD_HCNT_BITS-1:0] wr_addr,
  input  rgb_t                     wr_rgb,
  input  logic [`SD_HCNT_BITS-1:0] rd_addr,
  output rgb_t                     rd_rgb
);

  // top address bit picks the line half
  localparam int ADDR_BITS = `SD_HCNT_BITS + 1;
  localparam int DEPTH     = 1 << ADDR_BITS;

  // two lines of up to 1024 pixels each
  rgb_t mem [0:DEPTH-1];

  logic [ADDR_BITS-1:0] wr_ptr;
  logic [ADDR_BITS-1:0] rd_ptr;

  // the reader always works on the half not being filled
  assign wr_ptr = {wr_sel, wr_addr};
  assign rd_ptr = {~wr_sel, rd_addr};

  // ========================================
  // write port
  // ========================================

  always_ff @(posedge clk) begin
    if (pix_en) begin
      mem[wr_ptr] <= wr_rgb;
    end
  end

  // ========================================
  // read port
  // ========================================

  // registered read so the array maps onto block RAM
  always_ff @(posedge clk) begin
    rd_rgb <= mem[rd_ptr];
  end

endmodule

`default_nettype wire

//--- verilog/sd_line_timing.sv
// input line analysis for the scan doubler
// samples the source video whenever pix_en is high and measures
// the line length and hsync rise so the readout can replay the line
// also owns the ping-pong select and the 15 kHz flag

`timescale 1ns/1ps
`default_nettype none

`include "scan_doubler_defines.svh"

module sd_line_timing
  import scan_doubler_pkg::*;
(
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     pix_en,
  input  vid_t                     vid_in,
  output line_meas_t               meas,
  output logic [`SD_HCNT_BITS-1:0] wr_addr,
  output logic                     is15k
);

  // sync levels from the previous input sample
  logic hs_q;
  logic vs_q;

  // input pixel position inside the current line
  logic [`SD_HCNT_BITS-1:0] hcnt;

  // measured values handed to the later stages
  logic [`SD_HCNT_BITS-1:0] hs_max;
  logic [`SD_HCNT_BITS-1:0] hs_rise;
  logic                     line_sel;
  logic                     line_start;

  // edges between consecutive samples
  logic hs_fall;
  logic hs_rise_edge;
  logic vs_chg;

  assign hs_fall      = hs_q & ~vid_in.hs;
  assign hs_rise_edge = ~hs_q & vid_in.hs;
  assign vs_chg       = vs_q ^ vid_in.vs;

  // ========================================
  // pixel counter and measurement
  // ========================================

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      hs_q    <= 1'b0;
      vs_q    <= 1'b0;
      hcnt    <= '0;
      hs_max  <= '0;
      hs_rise <= '0;
    end else if (pix_en) begin
      hs_q <= vid_in.hs;
      vs_q <= vid_in.vs;
      // hsync falling edge starts a new line
      if (hs_fall) begin
        hs_max <= hcnt;
        hcnt   <= '0;
      end else begin
        hcnt <= hcnt + 1'b1;
      end
      // remember where the sync pulse ended
      if (hs_rise_edge) begin
        hs_rise <= hcnt;
      end
    end
  end

  // ========================================
  // line toggle and start pulse
  // ========================================

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      line_sel   <= 1'b0;
      line_start <= 1'b0;
    end else begin
      // pix_en is a single cycle strobe so this stays one clk wide
      line_start <= pix_en & hs_fall;
      if (pix_en) begin
        // hsync fall wins over a vsync change in the same sample
        if (hs_fall) begin
          line_sel <= ~line_sel;
        end else if (vs_chg) begin
          line_sel <= 1'b0;
        end
      end
    end
  end

  assign meas = '{
    hs_max:     hs_max,
    hs_rise:    hs_rise,
    line_sel:   line_sel,
    line_start: line_start
  };

  // write position follows the input counter
  assign wr_addr = hcnt;

  // long lines mean a slow line rate
  assign is15k = (hs_max > `SD_15K_LIMIT);

endmodule

`default_nettype wire

//--- verilog/sd_readout.sv
// double rate readout timing for the scan doubler
// replays the stored line twice per input line with its own hsync
// and lines the sync flags up with the one clk RAM latency
// rgb is blanked until the first measured line is in the buffer

`timescale 1ns/1ps
`default_nettype none

`include "scan_doubler_defines.svh"

module sd_readout
  import scan_doubler_pkg::*;
(
  input  logic                     clk,
  input  logic                     arst_n,
  input  line_meas_t               meas,
  input  logic                     vs_in,
  input  rgb_t                     rd_rgb,
  output logic [`SD_HCNT_BITS-1:0] rd_addr,
  output vid_t                     vid_rd
);

  // output pixel counter, runs every clk
  logic [`SD_HCNT_BITS-1:0] out_cnt;
  logic                     cnt_wrap;

  // regenerated hsync at counter timing
  logic hs_gen;

  // vsync sampled into the counter stage
  logic vs_q;

  // syncs one clk later to match the RAM read
  logic hs_d;
  logic vs_d;

  // buffer holds a full line once a line start has been seen
  logic active;
  logic active_d;

  assign cnt_wrap = (out_cnt == meas.hs_max);

  // ========================================
  // output counter and hsync
  // ========================================

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_cnt <= '0;
      hs_gen  <= 1'b0;
    end else begin
      // wrap beats the resync so a counter already at hs_max still wraps
      if (cnt_wrap) begin
        out_cnt <= '0;
      end else if (meas.line_start) begin
        out_cnt <= meas.hs_max;
      end else begin
        out_cnt <= out_cnt + 1'b1;
      end
      // sync goes low at the wrap and back high at the rise position
      if (out_cnt == meas.hs_rise) begin
        hs_gen <= 1'b1;
      end else if (cnt_wrap) begin
        hs_gen <= 1'b0;
      end
    end
  end

  // ========================================
  // sync delay and blanking
  // ========================================

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      vs_q     <= 1'b0;
      hs_d     <= 1'b0;
      vs_d     <= 1'b0;
      active   <= 1'b0;
      active_d <= 1'b0;
    end else begin
      vs_q     <= vs_in;
      hs_d     <= hs_gen;
      vs_d     <= vs_q;
      active   <= active | meas.line_start;
      active_d <= active;
    end
  end

  assign rd_addr = out_cnt;

  assign vid_rd.hs  = hs_d;
  assign vid_rd.vs  = vs_d;
  assign vid_rd.rgb = active_d ? rd_rgb : '0;

endmodule

`default_nettype wire

//--- verilog/sd_scanline.sv
// output register stage of the scan doubler
// keeps an output line phase and dims phase one lines according to
// the selected scanline mode, all outputs leave from flops

`timescale 1ns/1ps
`default_nettype none

`include "scan_doubler_defines.svh"

module sd_scanline
  import scan_doubler_pkg::*;
(
  input  logic     clk,
  input  logic     arst_n,
  input  sl_mode_t sl_mode,
  input  vid_t     vid_rd,
  output vid_t     vid_out
);

  // output line parity, one means a dimmed line
  logic phase;
  logic phase_nxt;

  logic hs_fall;
  logic vs_chg;
  rgb_t rgb_dim;

  // edges seen against the registered output
  assign hs_fall = vid_out.hs & ~vid_rd.hs;
  assign vs_chg  = vid_out.vs ^ vid_rd.vs;

  // new frame restarts on phase zero, each new line flips it
  always_comb begin
    phase_nxt = phase;
    if (vs_chg) begin
      phase_nxt = 1'b0;
    end else if (hs_fall) begin
      phase_nxt = ~phase;
    end
  end

  // one colour channel through the selected effect
  function automatic logic [`SD_COLOR_BITS-1:0] dim(
    input sl_mode_t                  mode,
    input logic [`SD_COLOR_BITS-1:0] c
  );
    case (mode)
      SL_HALF:    dim = c >> 1;
      // 75 percent brightness
      SL_QUARTER: dim = c - (c >> 2);
      default:    dim = c;
    endcase
  endfunction

  // phase_nxt so pixel 0 of the new line already gets its phase
  always_comb begin
    rgb_dim = vid_rd.rgb;
    if (phase_nxt) begin
      rgb_dim.r = dim(sl_mode, vid_rd.rgb.r);
      rgb_dim.g = dim(sl_mode, vid_rd.rgb.g);
      rgb_dim.b = dim(sl_mode, vid_rd.rgb.b);
    end
  end

  // ========================================
  // output register
  // ========================================

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      phase   <= 1'b0;
      vid_out <= '0;
    end else begin
      phase   <= phase_nxt;
      vid_out <= '{hs: vid_rd.hs, vs: vid_rd.vs, rgb: rgb_dim};
    end
  end

endmodule

`default_nettype wire
